// File: common/id_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface id_ctrl_if
    import id_pkg::*;
();

    aluop_e    aluop;
    alusel_e   alusel;
    reg_addr_t wd;
    logic      wreg;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    imm_fmt_e  imm_fmt;

    modport decoder (
        output aluop, alusel, wd, wreg,
        output reg1_read, reg2_read, reg1_addr, reg2_addr,
        output imm_fmt
    );

    modport consumer (
        input aluop, alusel, wd, wreg,
        input reg1_read, reg2_read, reg1_addr, reg2_addr,
        input imm_fmt
    );

endinterface

`default_nettype wire

// File: common/id_pkg.sv
`default_nettype none

package id_pkg;

    // Widths fixed by RV32I
    localparam int WORD_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by this stage
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OPI    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // F7_ALT selects SUB and SRA/SRAI
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_SUB  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_AND  = 5'd5,
        ALU_OR   = 5'd6,
        ALU_XOR  = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd10,
        ALU_BEQ  = 5'd11,
        ALU_BNE  = 5'd12,
        ALU_BLT  = 5'd13,
        ALU_BGE  = 5'd14,
        ALU_BLTU = 5'd15,
        ALU_BGEU = 5'd16
    } aluop_e;

    typedef enum logic [1:0] {
        SEL_NOP   = 2'd0,
        SEL_LOGIC = 2'd1,
        SEL_SHIFT = 2'd2,
        SEL_ARITH = 2'd3
    } alusel_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_SHAMT = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4
    } imm_fmt_e;

endpackage

`default_nettype wire

// File: decode/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen
    import id_pkg::*;
(
    input  inst_t       inst_i,
    id_ctrl_if.consumer ctrl,
    output word_t       imm_o
);

    always_comb begin
        case (ctrl.imm_fmt)
            IMM_I: begin
                imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            IMM_SHAMT: begin
                imm_o = {27'b0, inst_i[24:20]};
            end
            IMM_B: begin
                // Scattered offset bits, halfword aligned
                imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder
    import id_pkg::*;
(
    input  inst_t      inst_i,
    id_ctrl_if.decoder ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    aluop_e     op;
    alusel_e    sel;
    imm_fmt_e   fmt;
    logic       wr;
    logic       rd1_en;
    logic       rd2_en;
    logic       legal;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    always_comb begin
        op     = ALU_NOP;
        sel    = SEL_NOP;
        fmt    = IMM_NONE;
        wr     = 1'b0;
        rd1_en = 1'b0;
        rd2_en = 1'b0;
        legal  = 1'b0;
        case (opcode)
            OP_OP: begin
                // Only ADD/SUB and SRL/SRA accept the alternate funct7
                legal  = (funct7 == F7_BASE);
                wr     = 1'b1;
                rd1_en = 1'b1;
                rd2_en = 1'b1;
                case (funct3)
                    F3_ADD: begin
                        sel = SEL_ARITH;
                        case (funct7)
                            F7_BASE: op = ALU_ADD;
                            F7_ALT: begin
                                op    = ALU_SUB;
                                legal = 1'b1;
                            end
                            default: legal = 1'b0;
                        endcase
                    end
                    F3_SLT: begin
                        op  = ALU_SLT;
                        sel = SEL_ARITH;
                    end
                    F3_SLTU: begin
                        op  = ALU_SLTU;
                        sel = SEL_ARITH;
                    end
                    F3_AND: begin
                        op  = ALU_AND;
                        sel = SEL_LOGIC;
                    end
                    F3_OR: begin
                        op  = ALU_OR;
                        sel = SEL_LOGIC;
                    end
                    F3_XOR: begin
                        op  = ALU_XOR;
                        sel = SEL_LOGIC;
                    end
                    F3_SLL: begin
                        op  = ALU_SLL;
                        sel = SEL_SHIFT;
                    end
                    F3_SRL: begin
                        sel = SEL_SHIFT;
                        case (funct7)
                            F7_BASE: op = ALU_SRL;
                            F7_ALT: begin
                                op    = ALU_SRA;
                                legal = 1'b1;
                            end
                            default: legal = 1'b0;
                        endcase
                    end
                endcase
            end
            OP_OPI: begin
                // Second operand is the immediate, rs2 is not read
                legal  = 1'b1;
                wr     = 1'b1;
                rd1_en = 1'b1;
                fmt    = IMM_I;
                case (funct3)
                    F3_ADD: begin
                        op  = ALU_ADD;
                        sel = SEL_ARITH;
                    end
                    F3_SLT: begin
                        op  = ALU_SLT;
                        sel = SEL_ARITH;
                    end
                    F3_SLTU: begin
                        op  = ALU_SLTU;
                        sel = SEL_ARITH;
                    end
                    F3_AND: begin
                        op  = ALU_AND;
                        sel = SEL_LOGIC;
                    end
                    F3_OR: begin
                        op  = ALU_OR;
                        sel = SEL_LOGIC;
                    end
                    F3_XOR: begin
                        op  = ALU_XOR;
                        sel = SEL_LOGIC;
                    end
                    F3_SLL: begin
                        op    = ALU_SLL;
                        sel   = SEL_SHIFT;
                        fmt   = IMM_SHAMT;
                        legal = (funct7 == F7_BASE);
                    end
                    F3_SRL: begin
                        sel = SEL_SHIFT;
                        fmt = IMM_SHAMT;
                        case (funct7)
                            F7_BASE: op = ALU_SRL;
                            F7_ALT:  op = ALU_SRA;
                            default: legal = 1'b0;
                        endcase
                    end
                endcase
            end
            OP_LUI: begin
                // Executed as OR of the shifted immediate with itself
                legal = 1'b1;
                op    = ALU_OR;
                sel   = SEL_LOGIC;
                wr    = 1'b1;
                fmt   = IMM_U;
            end
            OP_BRANCH: begin
                legal  = 1'b1;
                rd1_en = 1'b1;
                rd2_en = 1'b1;
                fmt    = IMM_B;
                case (funct3)
                    F3_BEQ:  op = ALU_BEQ;
                    F3_BNE:  op = ALU_BNE;
                    F3_BLT:  op = ALU_BLT;
                    F3_BGE:  op = ALU_BGE;
                    F3_BLTU: op = ALU_BLTU;
                    F3_BGEU: op = ALU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Anything not recognised leaves the bundle as a NOP
    assign ctrl.aluop     = legal ? op : ALU_NOP;
    assign ctrl.alusel    = legal ? sel : SEL_NOP;
    assign ctrl.imm_fmt   = legal ? fmt : IMM_NONE;
    assign ctrl.wreg      = legal & wr;
    assign ctrl.wd        = (legal && wr) ? rd : '0;
    assign ctrl.reg1_read = legal & rd1_en;
    assign ctrl.reg2_read = legal & rd2_en;
    assign ctrl.reg1_addr = (legal && rd1_en) ? rs1 : '0;
    assign ctrl.reg2_addr = (legal && rd2_en) ? rs2 : '0;

endmodule

`default_nettype wire

// File: id_stage.f
+incdir+verification
common/id_pkg.sv
common/id_ctrl_if.sv
decode/inst_decoder.sv
decode/imm_gen.sv
verilog/operand_mux.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tb_id_stage -f id_stage.f > build.log 2>&1 \
    && ./obj_dir/Vtb_id_stage > sim.log 2>&1
grep -qs "^Test OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: verification/tb_id_model.svh
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// Expected state of every DUT output for one driven cycle
typedef struct packed {
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    aluop_e    aluop;
    alusel_e   alusel;
    reg_addr_t wd;
    logic      wreg;
    word_t     reg1;
    word_t     reg2;
    word_t     offset;
} id_expect_t;

// Register file contents, every address bit shows up in the word
function automatic word_t rf_word(reg_addr_t addr);
    return {addr, 3'b101, addr, 3'b011, addr, 3'b110, addr, 3'b001};
endfunction

function automatic alusel_e class_of(aluop_e op);
    case (op)
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: return SEL_ARITH;
        ALU_AND, ALU_OR, ALU_XOR:            return SEL_LOGIC;
        ALU_SLL, ALU_SRL, ALU_SRA:           return SEL_SHIFT;
        default:                             return SEL_NOP;
    endcase
endfunction

function automatic word_t pick_operand(logic use_reg, reg_addr_t addr, word_t imm,
                                       logic ex_we, reg_addr_t ex_wd, word_t ex_data,
                                       logic mem_we, reg_addr_t mem_wd, word_t mem_data);
    if (!use_reg) begin
        return imm;
    end
    if (ex_we && (ex_wd == addr)) begin
        return ex_data;
    end
    if (mem_we && (mem_wd == addr)) begin
        return mem_data;
    end
    return rf_word(addr);
endfunction

function automatic id_expect_t model_decode(inst_t inst, logic ex_we, reg_addr_t ex_wd,
                                            word_t ex_data, logic mem_we,
                                            reg_addr_t mem_wd, word_t mem_data);
    id_expect_t  e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [12:0] boff;
    word_t       imm;
    logic        use1;
    logic        use2;
    logic        legal;
    f3    = inst[14:12];
    f7    = inst[31:25];
    boff  = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    e     = '0;
    imm   = '0;
    use1  = 1'b0;
    use2  = 1'b0;
    legal = 1'b1;
    case (inst[6:0])
        OP_OP: begin
            use1   = 1'b1;
            use2   = 1'b1;
            e.wreg = 1'b1;
            case ({f7, f3})
                {F7_BASE, F3_ADD}:  e.aluop = ALU_ADD;
                {F7_ALT, F3_ADD}:   e.aluop = ALU_SUB;
                {F7_BASE, F3_SLL}:  e.aluop = ALU_SLL;
                {F7_BASE, F3_SLT}:  e.aluop = ALU_SLT;
                {F7_BASE, F3_SLTU}: e.aluop = ALU_SLTU;
                {F7_BASE, F3_XOR}:  e.aluop = ALU_XOR;
                {F7_BASE, F3_SRL}:  e.aluop = ALU_SRL;
                {F7_ALT, F3_SRL}:   e.aluop = ALU_SRA;
                {F7_BASE, F3_OR}:   e.aluop = ALU_OR;
                {F7_BASE, F3_AND}:  e.aluop = ALU_AND;
                default:            legal = 1'b0;
            endcase
        end
        OP_OPI: begin
            use1   = 1'b1;
            e.wreg = 1'b1;
            imm    = {{20{inst[31]}}, inst[31:20]};
            case (f3)
                F3_ADD:  e.aluop = ALU_ADD;
                F3_SLT:  e.aluop = ALU_SLT;
                F3_SLTU: e.aluop = ALU_SLTU;
                F3_AND:  e.aluop = ALU_AND;
                F3_OR:   e.aluop = ALU_OR;
                F3_XOR:  e.aluop = ALU_XOR;
                default: begin
                    // Shifts take a 5-bit amount, funct7 picks the kind
                    imm = {27'd0, inst[24:20]};
                    case ({f7, f3})
                        {F7_BASE, F3_SLL}: e.aluop = ALU_SLL;
                        {F7_BASE, F3_SRL}: e.aluop = ALU_SRL;
                        {F7_ALT, F3_SRL}:  e.aluop = ALU_SRA;
                        default:           legal = 1'b0;
                    endcase
                end
            endcase
        end
        OP_LUI: begin
            e.wreg  = 1'b1;
            e.aluop = ALU_OR;
            imm     = inst & 32'hFFFF_F000;
        end
        OP_BRANCH: begin
            use1 = 1'b1;
            use2 = 1'b1;
            imm  = {{19{boff[12]}}, boff};
            case (f3)
                F3_BEQ:  e.aluop = ALU_BEQ;
                F3_BNE:  e.aluop = ALU_BNE;
                F3_BLT:  e.aluop = ALU_BLT;
                F3_BGE:  e.aluop = ALU_BGE;
                F3_BLTU: e.aluop = ALU_BLTU;
                F3_BGEU: e.aluop = ALU_BGEU;
                default: legal = 1'b0;
            endcase
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        // Unknown encodings become a bubble
        e.aluop = ALU_NOP;
        e.wreg  = 1'b0;
        imm     = '0;
        use1    = 1'b0;
        use2    = 1'b0;
    end
    e.alusel    = class_of(e.aluop);
    e.wd        = e.wreg ? inst[11:7] : 5'd0;
    e.reg1_read = use1;
    e.reg2_read = use2;
    e.reg1_addr = use1 ? inst[19:15] : 5'd0;
    e.reg2_addr = use2 ? inst[24:20] : 5'd0;
    e.reg1      = pick_operand(use1, e.reg1_addr, imm, ex_we, ex_wd, ex_data,
                               mem_we, mem_wd, mem_data);
    e.reg2      = pick_operand(use2, e.reg2_addr, imm, ex_we, ex_wd, ex_data,
                               mem_we, mem_wd, mem_data);
    e.offset    = imm;
    return e;
endfunction

// Registered outputs cleared, read request still follows the instruction
function automatic id_expect_t reset_outputs(id_expect_t e);
    id_expect_t r;
    r           = '0;
    r.reg1_read = e.reg1_read;
    r.reg2_read = e.reg2_read;
    r.reg1_addr = e.reg1_addr;
    r.reg2_addr = e.reg2_addr;
    return r;
endfunction

`endif

// File: verification/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

    `include "tb_id_model.svh"

    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 400;
    // Slack covers the drain at the end
    localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 56;

    localparam logic [9:0] R_FUNCT [10] = '{
        {F7_BASE, F3_ADD}, {F7_ALT, F3_ADD}, {F7_BASE, F3_SLL}, {F7_BASE, F3_SLT},
        {F7_BASE, F3_SLTU}, {F7_BASE, F3_XOR}, {F7_BASE, F3_SRL}, {F7_ALT, F3_SRL},
        {F7_BASE, F3_OR}, {F7_BASE, F3_AND}
    };
    // Immediate and funct3, SRAI carries F7_ALT in the top bits
    localparam logic [14:0] I_CASES [9] = '{
        {12'hF85, F3_ADD}, {12'h7FF, F3_SLT}, {12'h800, F3_SLTU}, {12'hA5A, F3_AND},
        {12'h123, F3_OR}, {12'hFFF, F3_XOR}, {12'h01F, F3_SLL}, {12'h003, F3_SRL},
        {12'h40D, F3_SRL}
    };
    localparam logic [2:0] B_FUNCT [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    logic       clk;
    logic       rst_i;
    inst_t      inst_i;
    word_t      reg1_data_i;
    word_t      reg2_data_i;
    logic       ex_wreg_i;
    reg_addr_t  ex_wd_i;
    word_t      ex_wdata_i;
    logic       mem_wreg_i;
    reg_addr_t  mem_wd_i;
    word_t      mem_wdata_i;
    logic       reg1_read_o;
    logic       reg2_read_o;
    reg_addr_t  reg1_addr_o;
    reg_addr_t  reg2_addr_o;
    aluop_e     aluop_o;
    alusel_e    alusel_o;
    reg_addr_t  wd_o;
    logic       wreg_o;
    word_t      reg1_o;
    word_t      reg2_o;
    word_t      offset_o;
    id_expect_t exp_q;
    int         cycle_count = 0;
    int         error_count = 0;
    int         seed;

    id_stage DUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .reg1_o      (reg1_o),
        .reg2_o      (reg2_o),
        .offset_o    (offset_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    function automatic inst_t rtype_word(logic [9:0] f7f3, reg_addr_t rs2, reg_addr_t rs1,
                                         reg_addr_t rd);
        return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, OP_OP};
    endfunction

    function automatic inst_t itype_word(logic [14:0] imm_f3, reg_addr_t rs1, reg_addr_t rd);
        return {imm_f3[14:3], rs1, imm_f3[2:0], rd, OP_OPI};
    endfunction

    function automatic inst_t branch_word(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic inst_t lui_word(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OP_LUI};
    endfunction

    // One instruction per falling edge, register file answers from the model
    task automatic drive(input inst_t inst, input logic ex_we, input reg_addr_t ex_wd,
                         input word_t ex_data, input logic mem_we, input reg_addr_t mem_wd,
                         input word_t mem_data);
        id_expect_t e;
        @(negedge clk);
        e = model_decode(inst, ex_we, ex_wd, ex_data, mem_we, mem_wd, mem_data);
        rst_i       <= 1'b0;
        inst_i      <= inst;
        reg1_data_i <= rf_word(e.reg1_addr);
        reg2_data_i <= rf_word(e.reg2_addr);
        ex_wreg_i   <= ex_we;
        ex_wd_i     <= ex_wd;
        ex_wdata_i  <= ex_data;
        mem_wreg_i  <= mem_we;
        mem_wd_i    <= mem_wd;
        mem_wdata_i <= mem_data;
        exp_q       <= e;
    endtask

    task automatic random_legal(output inst_t inst);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $random(seed);
        f3 = r[14:12];
        case (r[1:0])
            2'd0: begin
                f7   = (r[31] && (f3 == F3_ADD || f3 == F3_SRL)) ? F7_ALT : F7_BASE;
                inst = {f7, r[24:7], OP_OP};
            end
            2'd1: begin
                f7 = r[31:25];
                if (f3 == F3_SLL) begin
                    f7 = F7_BASE;
                end else if (f3 == F3_SRL) begin
                    f7 = r[30] ? F7_ALT : F7_BASE;
                end
                inst = {f7, r[24:7], OP_OPI};
            end
            2'd2: inst = {r[31:7], OP_LUI};
            default: begin
                // Fold 010 and 011 onto BEQ and BNE
                f3   = {f3[2], f3[2] & f3[1], f3[0]};
                inst = {r[31:15], f3, r[11:7], OP_BRANCH};
            end
        endcase
    endtask

    // Outputs are stable at the falling edge, a full cycle after the inputs
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_value("reg1_read_o", 32'(reg1_read_o), 32'(exp_q.reg1_read));
            check_value("reg2_read_o", 32'(reg2_read_o), 32'(exp_q.reg2_read));
            check_value("reg1_addr_o", 32'(reg1_addr_o), 32'(exp_q.reg1_addr));
            check_value("reg2_addr_o", 32'(reg2_addr_o), 32'(exp_q.reg2_addr));
            check_value("aluop_o", 32'(aluop_o), 32'(exp_q.aluop));
            check_value("alusel_o", 32'(alusel_o), 32'(exp_q.alusel));
            check_value("wd_o", 32'(wd_o), 32'(exp_q.wd));
            check_value("wreg_o", 32'(wreg_o), 32'(exp_q.wreg));
            check_value("reg1_o", reg1_o, exp_q.reg1);
            check_value("reg2_o", reg2_o, exp_q.reg2);
            check_value("offset_o", offset_o, exp_q.offset);
        end
    end

    initial begin
        inst_t       inst;
        logic [31:0] r;
        word_t       ex_data;
        word_t       mem_data;
        seed        = 15353;
        rst_i       = 1'b1;
        inst_i      = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        exp_q       = reset_outputs(model_decode('0, 1'b0, '0, '0, 1'b0, '0, '0));
        repeat (RESET_CYCLES) @(posedge clk);

        // All-zero word right after reset is still a bubble
        drive('0, 1'b0, '0, '0, 1'b0, '0, '0);

        // Forward addresses match but the write enables are low
        for (int i = 0; i < 10; i++) begin
            drive(rtype_word(R_FUNCT[i], 5'(i + 3), 5'(i + 1), 5'(i + 10)),
                  1'b0, 5'(i + 1), 32'h1111_0000, 1'b0, 5'(i + 3), 32'h2222_0000);
        end
        for (int i = 0; i < 9; i++) begin
            drive(itype_word(I_CASES[i], 5'(i + 7), 5'(i + 20)),
                  1'b0, '0, '0, 1'b0, '0, '0);
        end

        // Both stages hold x5, execute is younger
        drive(rtype_word({F7_BASE, F3_ADD}, 5'd6, 5'd5, 5'd9),
              1'b1, 5'd5, 32'hAAAA_0001, 1'b1, 5'd5, 32'hBBBB_0001);
        drive(rtype_word({F7_ALT, F3_ADD}, 5'd6, 5'd5, 5'd9),
              1'b1, 5'd7, 32'hAAAA_0002, 1'b1, 5'd6, 32'hBBBB_0002);
        drive(rtype_word({F7_BASE, F3_XOR}, 5'd6, 5'd5, 5'd9),
              1'b1, 5'd5, 32'hAAAA_0003, 1'b1, 5'd6, 32'hBBBB_0003);
        drive(rtype_word({F7_BASE, F3_OR}, 5'd6, 5'd5, 5'd9),
              1'b0, 5'd5, 32'hAAAA_0004, 1'b1, 5'd5, 32'hBBBB_0004);
        // x0 forwards like any other register
        drive(rtype_word({F7_BASE, F3_AND}, 5'd0, 5'd0, 5'd1),
              1'b1, 5'd0, 32'hAAAA_0005, 1'b0, '0, '0);
        // LUI reads nothing, so a matching x0 forward must be ignored
        drive(lui_word(20'hDEADB, 5'd17), 1'b1, 5'd0, 32'hAAAA_0006, 1'b1, 5'd0, 32'hBBBB_0006);

        for (int i = 0; i < 6; i++) begin
            drive(branch_word(13'(i * 1500 + 100), 5'(i + 20), 5'(i + 14), B_FUNCT[i]),
                  1'b1, 5'(i + 20), 32'hCCCC_0000, 1'b0, '0, '0);
        end
        drive(lui_word(20'h00001, 5'd0), 1'b0, '0, '0, 1'b0, '0, '0);
        drive(branch_word(13'h0040, 5'd3, 5'd4, 3'b010), 1'b0, '0, '0, 1'b0, '0, '0);
        drive(rtype_word({7'b0000001, F3_ADD}, 5'd3, 5'd4, 5'd5), 1'b0, '0, '0, 1'b0, '0, '0);
        drive(32'hFFFF_FFFF, 1'b0, '0, '0, 1'b0, '0, '0);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'b11) begin
                inst = $random(seed);
            end else begin
                random_legal(inst);
            end
            r        = $random(seed);
            ex_data  = $random(seed);
            mem_data = $random(seed);
            drive(inst, r[13], r[1] ? inst[19:15] : r[6:2], ex_data,
                  r[14], r[7] ? inst[24:20] : r[12:8], mem_data);
        end

        @(negedge clk);
        @(posedge clk);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg
    import id_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    id_ctrl_if.consumer ctrl,
    input  word_t       reg1_i,
    input  word_t       reg2_i,
    input  word_t       imm_i,
    output aluop_e      aluop_o,
    output alusel_e     alusel_o,
    output reg_addr_t   wd_o,
    output logic        wreg_o,
    output word_t       reg1_o,
    output word_t       reg2_o,
    output word_t       offset_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // Bubble with every field cleared
            aluop_o  <= ALU_NOP;
            alusel_o <= SEL_NOP;
            wd_o     <= '0;
            wreg_o   <= 1'b0;
            reg1_o   <= '0;
            reg2_o   <= '0;
            offset_o <= '0;
        end else begin
            aluop_o  <= ctrl.aluop;
            alusel_o <= ctrl.alusel;
            wd_o     <= ctrl.wd;
            wreg_o   <= ctrl.wreg;
            reg1_o   <= reg1_i;
            reg2_o   <= reg2_i;
            // branch offset or LUI value for execute
            offset_o <= imm_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  inst_t     inst_i,

    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,

    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,

    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,

    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,

    output aluop_e    aluop_o,
    output alusel_e   alusel_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output word_t     offset_o
);

    id_ctrl_if ctrl ();

    word_t imm;
    word_t opnd1;
    word_t opnd2;

    // Register file requests go out in the same cycle as the instruction
    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;
    assign reg1_addr_o = ctrl.reg1_addr;
    assign reg2_addr_o = ctrl.reg2_addr;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl   (ctrl.decoder)
    );

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .ctrl   (ctrl.consumer),
        .imm_o  (imm)
    );

    operand_mux u_opnd1_mux (
        .read_i      (ctrl.reg1_read),
        .addr_i      (ctrl.reg1_addr),
        .rf_data_i   (reg1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (opnd1)
    );

    operand_mux u_opnd2_mux (
        .read_i      (ctrl.reg2_read),
        .addr_i      (ctrl.reg2_addr),
        .rf_data_i   (reg2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (opnd2)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .ctrl     (ctrl.consumer),
        .reg1_i   (opnd1),
        .reg2_i   (opnd2),
        .imm_i    (imm),
        .aluop_o  (aluop_o),
        .alusel_o (alusel_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o),
        .reg1_o   (reg1_o),
        .reg2_o   (reg2_o),
        .offset_o (offset_o)
    );

endmodule

`default_nettype wire

// File: verilog/operand_mux.sv
`timescale 1ns/10ps
`default_nettype none

module operand_mux
    import id_pkg::*;
(
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    // Youngest producer wins, so execute is checked before memory
    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_wreg_i && (ex_wd_i == addr_i)) begin
            operand_o = ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr_i)) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire
